/* tests/apu_timing_input.txt */
# Columns: op arg_a arg_b name, both arguments in hex.
# P cycles | W offset byte | A aclk_count | R offset expected | L lfo1 lfo2 | Q int_out | D dmc_int
# Divider phases over 32 CPU cycles.
P 20 0 divider_phase
# Four-step frame, 14915 APU cycles reach step 4.
W 17 00 four_step_write
A 3a43 0 four_step_wait
L 4 2 four_step_lfo
Q 1 0 four_step_int_out
R 15 40 four_step_status
# A status read clears the frame interrupt.
R 15 00 status_cleared
Q 0 0 cleared_int_out
# Inhibit set, a full frame raises nothing.
W 17 40 inhibit_write
A 3a43 0 inhibit_wait
L 4 2 inhibit_lfo
R 15 00 inhibit_status
Q 0 0 inhibit_int_out
# Five-step frame, the write clocks both strobes at once, 18641 APU cycles to step 5.
W 17 80 five_step_write
L 1 1 five_step_write_lfo
A 48d1 0 five_step_wait
L 5 3 five_step_lfo
R 15 00 five_step_status
Q 0 0 five_step_int_out
# DMC interrupt passes straight through.
D 1 0 dmc_set
Q 1 0 dmc_int_out
R 15 80 dmc_status
D 0 0 dmc_clear
Q 0 0 dmc_clear_int_out
R 15 00 dmc_clear_status

/* apu_timing.f */
+incdir+rtl
rtl/apu_clock_pkg.sv
rtl/apu_reg_pkg.sv
rtl/cpu_clock_divider.sv
rtl/apu_cycle_gen.sv
rtl/frame_sequencer.sv
rtl/apu_reg_decoder.sv
rtl/apu_timing_top.sv
tests/apu_timing_checker.sv
tests/apu_timing_tb.sv

/* Makefile */
TOP := apu_timing_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f apu_timing.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* tests/apu_timing_tb.sv */
`timescale 1ns/10ps

module apu_timing_tb;

	localparam int MAX_CMDS = 64;

	logic                   clk;
	logic                   rst_n;
	apu_reg_pkg::reg_addr_t reg_addr;
	logic                   reg_wr;
	logic                   reg_rd;
	apu_reg_pkg::reg_data_t wr_data;
	logic                   dmc_int;
	logic                   phi1, phi2, m2, cpu_cycle, aclk;
	apu_reg_pkg::reg_data_t rd_data;
	logic                   int_out, lfo1, lfo2;

	logic [7:0]      op_mem[MAX_CMDS];
	logic [31:0]     a_mem[MAX_CMDS];
	logic [31:0]     b_mem[MAX_CMDS];
	logic [8*32-1:0] name_mem[MAX_CMDS];
	int              n_cmds;
	longint          limit_ns;
	logic            limit_ready;
	int              lfo1_total;
	int              lfo2_total;
	int              lfo1_base;
	int              lfo2_base;

	apu_timing_top dut_i (.*);

	bind apu_timing_top apu_timing_checker checker_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_cycle (cpu_cycle),
		.phi1      (phi1),
		.phi2      (phi2),
		.aclk      (aclk),
		.lfo1      (lfo1),
		.lfo2      (lfo2)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Strobes are counted mid-period where they are stable.
	always @(negedge clk) begin
		if (lfo1) lfo1_total <= lfo1_total + 1;
		if (lfo2) lfo2_total <= lfo2_total + 1;
	end

	// ***********************************************************
	// Helpers
	// ***********************************************************
	task automatic stop_with_failure();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped after a failure.");
	endtask

	task automatic check_value(input logic [8*32-1:0] name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %0s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic load_commands();
		int               fd;
		int               got;
		logic [8*120-1:0] text_line;
		logic [7:0]       op;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [8*32-1:0]  nm;
		longint           clocks;
		clocks = 2000;                         // Reset and slack.
		n_cmds = 0;
		fd = $fopen("tests/apu_timing_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the command file tests/apu_timing_input.txt.");
			stop_with_failure();
		end
		text_line = '0;
		while ($fgets(text_line, fd) != 0) begin
			op = 8'h00;
			nm = '0;
			got = $sscanf(text_line, "%s %h %h %s", op, a, b, nm);
			if (got == 4 && op != "#" && n_cmds < MAX_CMDS) begin
				op_mem[n_cmds]   = op;
				a_mem[n_cmds]    = a;
				b_mem[n_cmds]    = b;
				name_mem[n_cmds] = nm;
				n_cmds           = n_cmds + 1;
				clocks           = clocks + 48;
				if (op == "A") clocks = clocks + longint'(a) * 24;   // Two CPU cycles each.
				if (op == "P") clocks = clocks + longint'(a) * 12;
			end
			text_line = '0;
		end
		$fclose(fd);
		limit_ns    = clocks * 40;
		limit_ready = 1'b1;
	endtask

	// Inputs change on the clock before cpu_cycle and drop after it.
	task automatic bus_cycle(input logic [4:0] addr, input logic wr, input logic rd,
			input logic [7:0] data, output logic [7:0] rdata);
		@(negedge clk);
		while (!cpu_cycle) @(negedge clk);
		repeat (11) @(posedge clk);
		if (wr) begin
			lfo1_base = lfo1_total;
			lfo2_base = lfo2_total;
		end
		reg_addr <= addr;
		reg_wr   <= wr;
		reg_rd   <= rd;
		wr_data  <= data;
		@(posedge clk);
		@(negedge clk);
		rdata = rd_data;                       // Valid in the cpu_cycle period.
		@(posedge clk);
		reg_wr <= 1'b0;
		reg_rd <= 1'b0;
	endtask

	task automatic wait_aclk(input logic [31:0] n);
		repeat (n) begin
			@(negedge clk);
			while (!aclk) @(negedge clk);
		end
	endtask

	// Bits are cpu_cycle, m2, phi2, phi1 against the divider position.
	task automatic scan_divider_phases(input int i);
		int         pos;
		logic [3:0] want;
		@(negedge clk);
		while (!cpu_cycle) @(negedge clk);
		pos = 11;
		repeat (a_mem[i] * 12) begin
			@(negedge clk);
			pos  = (pos == 11) ? 0 : pos + 1;
			want = {pos == 11, pos >= 5, pos >= 6, pos < 6};
			check_value(name_mem[i], {28'd0, want}, {28'd0, cpu_cycle, m2, phi2, phi1});
		end
	endtask

	task automatic run_command(input int i);
		logic [7:0] data;
		case (op_mem[i])
			"P": scan_divider_phases(i);
			"W": bus_cycle(a_mem[i][4:0], 1'b1, 1'b0, b_mem[i][7:0], data);
			"R": begin
				bus_cycle(a_mem[i][4:0], 1'b0, 1'b1, 8'h00, data);
				check_value(name_mem[i], b_mem[i], {24'd0, data});
			end
			"A": wait_aclk(a_mem[i]);
			"L": begin
				@(posedge clk);
				check_value(name_mem[i], a_mem[i], lfo1_total - lfo1_base);
				check_value(name_mem[i], b_mem[i], lfo2_total - lfo2_base);
			end
			"Q": begin
				@(posedge clk);
				@(negedge clk);
				check_value(name_mem[i], a_mem[i], {31'd0, int_out});
			end
			"D": begin
				@(posedge clk);
				dmc_int <= a_mem[i][0];
			end
			default: begin
				$display("Unknown command in line %0d of the command file.", i);
				stop_with_failure();
			end
		endcase
	endtask

	// ***********************************************************
	// Main flow and watchdog
	// ***********************************************************
	initial begin : main_flow
		int idx;
		rst_n       = 1'b0;
		reg_addr    = '0;
		reg_wr      = 1'b0;
		reg_rd      = 1'b0;
		wr_data     = '0;
		dmc_int     = 1'b0;
		limit_ready = 1'b0;
		load_commands();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (idx = 0; idx < n_cmds; idx++) begin
			run_command(idx);
		end
		$display("NO ERRORS");
		$finish;
	end

	initial begin : watchdog
		wait (limit_ready);
		#(limit_ns);
		$display("Timeout, the command list did not finish within %0d ns.", limit_ns);
		stop_with_failure();
	end

endmodule

/* tests/apu_timing_checker.sv */
`timescale 1ns/10ps

module apu_timing_checker (
	input logic clk,
	input logic rst_n,
	input logic cpu_cycle,
	input logic phi1,
	input logic phi2,
	input logic aclk,
	input logic lfo1,
	input logic lfo2
);

	logic [3:0] gap;                           // Clocks since the last cpu_cycle.
	logic       seen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gap  <= '0;
			seen <= 1'b0;
		end else if (cpu_cycle) begin
			gap  <= '0;
			seen <= 1'b1;
		end else if (gap != 4'hf) begin
			gap <= gap + 4'd1;
		end
	end

	// ***********************************************************
	// Divider and strobe rules
	// ***********************************************************
	cycle_gap_a: assert property (@(posedge clk) disable iff (!rst_n)
		seen |-> (cpu_cycle == (gap == 4'd11)))
		else $error("cpu_cycle is not spaced by eleven idle clocks");

	// Gap equals the divider position once cpu_cycle has been seen.
	phase_overlap_a: assert property (@(posedge clk) disable iff (!rst_n)
		seen |-> ((phi1 != phi2) && (phi2 == (gap >= 4'd6))))
		else $error("phi1 and phi2 overlap or are off their divider position");

	// Every second cpu_cycle, starting with the second one after reset.
	aclk_align_a: assert property (@(posedge clk) disable iff (!rst_n)
		aclk == (cpu_cycle && seen && !$past(aclk, 12)))
		else $error("aclk is not on every second cpu_cycle");

	lfo_pair_a: assert property (@(posedge clk) disable iff (!rst_n)
		(lfo1 || lfo2) |-> (lfo1 && (aclk || $past(cpu_cycle))))
		else $error("lfo strobe without lfo1 or off the APU cycle");

endmodule

/* rtl/apu_timing_top.sv */
`timescale 1ns/10ps

module apu_timing_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  apu_reg_pkg::reg_addr_t reg_addr,
	input  logic                   reg_wr,
	input  logic                   reg_rd,
	input  apu_reg_pkg::reg_data_t wr_data,
	input  logic                   dmc_int,
	output logic                   phi1,
	output logic                   phi2,
	output logic                   m2,
	output logic                   cpu_cycle,
	output logic                   aclk,
	output apu_reg_pkg::reg_data_t rd_data,
	output logic                   int_out,
	output logic                   lfo1,
	output logic                   lfo2
);

	logic frame_wr;
	logic mode_bit;
	logic inhibit_bit;
	logic status_rd;
	logic frame_irq;

	// ***********************************************************
	// Clock section
	// ***********************************************************
	cpu_clock_divider divider_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.phi1      (phi1),
		.phi2      (phi2),
		.m2        (m2),
		.cpu_cycle (cpu_cycle)
	);

	apu_cycle_gen cycle_gen_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_cycle (cpu_cycle),
		.aclk      (aclk)
	);

	// ***********************************************************
	// Frame counter and register port
	// ***********************************************************
	frame_sequencer sequencer_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.aclk        (aclk),
		.frame_wr    (frame_wr),
		.mode_bit    (mode_bit),
		.inhibit_bit (inhibit_bit),
		.status_rd   (status_rd),
		.frame_irq   (frame_irq),
		.lfo1        (lfo1),
		.lfo2        (lfo2)
	);

	apu_reg_decoder decoder_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.cpu_cycle   (cpu_cycle),
		.reg_addr    (reg_addr),
		.reg_wr      (reg_wr),
		.reg_rd      (reg_rd),
		.wr_data     (wr_data),
		.frame_irq   (frame_irq),
		.dmc_int     (dmc_int),
		.frame_wr    (frame_wr),
		.mode_bit    (mode_bit),
		.inhibit_bit (inhibit_bit),
		.status_rd   (status_rd),
		.rd_data     (rd_data),
		.int_out     (int_out)
	);

endmodule

/* rtl/apu_reg_decoder.sv */
`timescale 1ns/10ps
`include "apu_timing_defines.svh"

module apu_reg_decoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cpu_cycle,
	input  apu_reg_pkg::reg_addr_t reg_addr,
	input  logic                  reg_wr,
	input  logic                  reg_rd,
	input  apu_reg_pkg::reg_data_t wr_data,
	input  logic                  frame_irq,
	input  logic                  dmc_int,
	output logic                  frame_wr,
	output logic                  mode_bit,
	output logic                  inhibit_bit,
	output logic                  status_rd,
	output apu_reg_pkg::reg_data_t rd_data,
	output logic                  int_out
);

	logic frame_hit;
	logic status_hit;

	// Bus is only sampled at the end of a CPU cycle.
	assign frame_hit  = cpu_cycle && reg_wr && (reg_addr == `APU_REG_FRAME);
	assign status_hit = cpu_cycle && reg_rd && (reg_addr == `APU_REG_STATUS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_wr  <= 1'b0;
			status_rd <= 1'b0;
		end else begin
			frame_wr  <= frame_hit;
			status_rd <= status_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (frame_hit) begin
			mode_bit    <= wr_data[7];          // 1 selects five-step mode.
			inhibit_bit <= wr_data[6];
		end
	end

	always_comb begin
		rd_data = '0;
		if (reg_rd && (reg_addr == `APU_REG_STATUS)) begin
			rd_data[7] = dmc_int;
			rd_data[6] = frame_irq;
		end
	end

	assign int_out = frame_irq | dmc_int;       // Shared IRQ line.

endmodule

/* rtl/frame_sequencer.sv */
`timescale 1ns/10ps
`include "apu_timing_defines.svh"

module frame_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic aclk,
	input  logic frame_wr,
	input  logic mode_bit,
	input  logic inhibit_bit,
	input  logic status_rd,
	output logic frame_irq,
	output logic lfo1,
	output logic lfo2
);

	apu_clock_pkg::aclk_count_t cnt;
	apu_reg_pkg::frame_mode_t   mode;
	logic                       inhibit;

	logic at_step1;
	logic at_step2;
	logic at_step3;
	logic at_step4;
	logic at_step5;
	logic four_end;
	logic frame_end;
	logic wr_five;

	// ***********************************************************
	// Step decode
	// ***********************************************************
	always_comb begin
		at_step1  = aclk && (cnt == `APU_STEP1);
		at_step2  = aclk && (cnt == `APU_STEP2);
		at_step3  = aclk && (cnt == `APU_STEP3);
		at_step4  = aclk && (cnt == `APU_STEP4);
		at_step5  = aclk && (cnt == `APU_STEP5) && (mode == apu_reg_pkg::mode_five);
		four_end  = at_step4 && (mode == apu_reg_pkg::mode_four);
		frame_end = four_end || at_step5;
		wr_five   = frame_wr && mode_bit;          // Write kicks both clocks at once.
	end

	// Step 4 is silent in five-step mode.
	assign lfo1 = wr_five | at_step1 | at_step2 | at_step3 | four_end | at_step5;
	assign lfo2 = wr_five | at_step2 | four_end | at_step5;

	// ***********************************************************
	// APU cycle counter
	// ***********************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (frame_wr || frame_end) begin
			cnt <= '0;                          // Restart of the frame.
		end else if (aclk) begin
			cnt <= cnt + 15'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode    <= apu_reg_pkg::mode_four;
			inhibit <= 1'b0;
		end else if (frame_wr) begin
			mode    <= mode_bit ? apu_reg_pkg::mode_five : apu_reg_pkg::mode_four;
			inhibit <= inhibit_bit;
		end
	end

	// ***********************************************************
	// Frame interrupt
	// ***********************************************************
	// A status read clears the flag one clock late, so the read
	// itself still sees it set.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_irq <= 1'b0;
		end else if (frame_wr && inhibit_bit) begin
			frame_irq <= 1'b0;
		end else if (status_rd) begin
			frame_irq <= 1'b0;
		end else if (four_end && !inhibit) begin
			frame_irq <= 1'b1;
		end
	end

endmodule

/* rtl/apu_cycle_gen.sv */
`timescale 1ns/10ps

module apu_cycle_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic cpu_cycle,
	output logic aclk
);

	// APU phase toggle, one APU cycle is two CPU cycles.
	logic phase;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= 1'b0;                     // Held clear in reset.
		end else if (cpu_cycle) begin
			phase <= ~phase;
		end
	end

	// First cpu_cycle after reset only sets the phase, the second one
	// produces the first aclk.
	assign aclk = cpu_cycle & phase;

endmodule

/* rtl/cpu_clock_divider.sv */
`timescale 1ns/10ps
`include "apu_timing_defines.svh"

module cpu_clock_divider (
	input  logic clk,
	input  logic rst_n,
	output logic phi1,
	output logic phi2,
	output logic m2,
	output logic cpu_cycle
);

	apu_clock_pkg::div_count_t cnt;
	apu_clock_pkg::div_count_t cnt_nxt;

	always_comb begin
		if (cnt == `APU_DIV_LEN - 4'd1) begin
			cnt_nxt = '0;
		end else begin
			cnt_nxt = cnt + 4'd1;
		end
	end

	// Outputs are compared on the next count so they line up with cnt.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt       <= '0;
			phi1      <= 1'b1;                 // Count 0 is in phi1.
			phi2      <= 1'b0;
			m2        <= 1'b0;
			cpu_cycle <= 1'b0;
		end else begin
			cnt       <= cnt_nxt;
			phi1      <= (cnt_nxt < `APU_PHI2_START);
			phi2      <= (cnt_nxt >= `APU_PHI2_START);
			m2        <= (cnt_nxt >= `APU_M2_START);   // Stretched M2.
			cpu_cycle <= (cnt_nxt == `APU_DIV_LEN - 4'd1);
		end
	end

endmodule

/* rtl/apu_reg_pkg.sv */
`include "apu_timing_defines.svh"

package apu_reg_pkg;

	typedef logic [`APU_ADDR_W-1:0] reg_addr_t;   // Offset from $4000.
	typedef logic [`APU_DATA_W-1:0] reg_data_t;   // One bus byte.

	// Frame sequencer mode, bit 7 of $4017.
	typedef enum logic {
		mode_four = 1'b0,
		mode_five = 1'b1
	} frame_mode_t;

endpackage

/* rtl/apu_clock_pkg.sv */
`include "apu_timing_defines.svh"

package apu_clock_pkg;

	// Position inside one CPU cycle, 0 to 11.
	typedef logic [`APU_DIV_W-1:0] div_count_t;

	// APU cycles since the frame started.
	typedef logic [`APU_ACLK_W-1:0] aclk_count_t;

endpackage

/* rtl/apu_timing_defines.svh */
`ifndef APU_TIMING_DEFINES_SVH
`define APU_TIMING_DEFINES_SVH

// ***********************************************************
// Vector widths
// ***********************************************************
`define APU_DIV_W        4                // Divider position.
`define APU_ACLK_W       15               // APU cycle count.
`define APU_ADDR_W       5                // Register offset.
`define APU_DATA_W       8                // CPU data bus.

// ***********************************************************
// CPU clock divider
// ***********************************************************
`define APU_DIV_LEN      4'd12            // Master clocks per CPU cycle.
`define APU_PHI2_START   4'd6             // First count of phi2.
`define APU_M2_START     4'd5             // M2 rises one count early.

// Frame steps in APU cycles.
`define APU_STEP1        15'd3728
`define APU_STEP2        15'd7456
`define APU_STEP3        15'd11185
`define APU_STEP4        15'd14914
`define APU_STEP5        15'd18640        // Five-step mode only.

`define APU_REG_STATUS   5'h15            // $4015 read.
`define APU_REG_FRAME    5'h17            // $4017 write.

`endif
